// File: hdl/mips_isa_pkg.sv
package mips_isa_pkg;

	// primary opcode, bits 31:26
	typedef enum logic [5:0] {
		op_r_type = 6'h00,	// funct selects the operation
		op_j      = 6'h02,
		op_jal    = 6'h03,
		op_beq    = 6'h04,
		op_bne    = 6'h05,
		op_addi   = 6'h08,
		op_andi   = 6'h0c,
		op_ori    = 6'h0d,
		op_lw     = 6'h23,
		op_sw     = 6'h2b
	} opcode_e;

	// funct field of r-type, bits 5:0
	typedef enum logic [5:0] {
		fn_sll = 6'h00,	// shift by shamt, rs unused
		fn_add = 6'h20,
		fn_sub = 6'h22,
		fn_and = 6'h24,
		fn_or  = 6'h25,
		fn_slt = 6'h2a	// signed compare
	} funct_e;

	typedef struct packed {
		opcode_e     opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;	// destination for r-type
		logic [4:0]  shamt;
		funct_e      funct;
	} r_fmt_t;

	typedef struct packed {
		opcode_e     opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;	// destination for alu-immediate and lw
		logic [15:0] imm16;	// sign or zero extended by the datapath
	} i_fmt_t;

	typedef struct packed {
		opcode_e     opcode;
		logic [25:0] target26;	// word index inside the current 256 MB region
	} j_fmt_t;

	// same 32-bit word seen through each format
	typedef union packed {
		r_fmt_t      r;
		i_fmt_t      i;
		j_fmt_t      j;
		logic [31:0] raw;	// as read from memory
	} instr_u;

	localparam logic [4:0] ra_reg = 5'd31;	// link register for jal

endpackage

// File: hdl/mips_ctrl_pkg.sv
package mips_ctrl_pkg;

	typedef enum logic [3:0] {
		st_fetch,
		st_decode,
		st_mem_addr,	// lw/sw effective address
		st_mem_read,
		st_mem_wb,
		st_mem_write,
		st_r_exec,
		st_i_exec,
		st_alu_wb,	// shared by r-type and immediate alu
		st_branch,
		st_jump	// j and jal
	} state_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt,
		alu_sll
	} alu_op_e;

	typedef enum logic [1:0] {
		src_a_pc,
		src_a_reg_a,
		src_a_shamt
	} src_a_e;

	typedef enum logic [1:0] {
		src_b_reg_b,
		src_b_four,
		src_b_ext,
		src_b_ext_shifted	// branch offset in bytes
	} src_b_e;

	typedef enum logic [1:0] {
		pc_src_alu_result,	// pc + 4 during fetch
		pc_src_alu_out,	// branch target from decode
		pc_src_jump_target
	} pc_src_e;

	typedef enum logic [1:0] {
		reg_dst_rt,
		reg_dst_rd,
		reg_dst_link
	} reg_dst_e;

	typedef enum logic [1:0] {
		branch_none,
		branch_on_zero,	// beq
		branch_on_not_zero	// bne
	} branch_e;

	typedef struct packed {
		logic     pc_write;	// unconditional pc update
		logic     i_or_d;	// memory address from alu_out instead of pc
		logic     mem_write;
		logic     ir_write;
		logic     reg_write;
		logic     mem_to_reg;	// write-back from memory-data register
		logic     zero_ext;	// andi/ori immediates
		alu_op_e  alu_op;
		src_a_e   src_a;
		src_b_e   src_b;
		pc_src_e  pc_src;
		reg_dst_e reg_dst;
		branch_e  branch;
	} ctrl_t;

	// all strobes low, alu idling on an add
	localparam ctrl_t ctrl_default = '{
		pc_write:   1'b0,
		i_or_d:     1'b0,
		mem_write:  1'b0,
		ir_write:   1'b0,
		reg_write:  1'b0,
		mem_to_reg: 1'b0,
		zero_ext:   1'b0,
		alu_op:     alu_add,
		src_a:      src_a_pc,
		src_b:      src_b_reg_b,
		pc_src:     pc_src_alu_result,
		reg_dst:    reg_dst_rt,
		branch:     branch_none
	};

endpackage

// File: hdl/alu.sv
`timescale 1ns/10ps

module alu (
	input  logic [31:0]             a,
	input  logic [31:0]             b,
	input  mips_ctrl_pkg::alu_op_e  op,
	output logic [31:0]             result,
	output logic                    zero
);
	import mips_ctrl_pkg::*;

	always_comb begin
		case (op)
			alu_add: begin
				result = a + b;
			end
			alu_sub: begin
				result = a - b;	// beq/bne compare
			end
			alu_and: begin
				result = a & b;
			end
			alu_or: begin
				result = a | b;
			end
			alu_slt: begin
				// signed compare, 1 or 0
				result = {31'b0, $signed(a) < $signed(b)};
			end
			alu_sll: begin
				result = b << a[4:0];	// a carries the shift amount
			end
			default: begin
				result = '0;
			end
		endcase
	end

	assign zero = (result == 32'b0);

endmodule

// File: hdl/register_file.sv
`timescale 1ns/10ps

module register_file (
	input  logic        clk,
	input  logic        rstb,
	input  logic [4:0]  rd_addr_a,
	input  logic [4:0]  rd_addr_b,
	input  logic        wr_ena,
	input  logic [4:0]  wr_addr,
	input  logic [31:0] wr_data,
	output logic [31:0] rd_data_a,
	output logic [31:0] rd_data_b
);

	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (!rstb) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_ena && (wr_addr != 5'd0)) begin
			regs[wr_addr] <= wr_data;	// r0 is never stored
		end
	end

	// combinational reads, r0 hardwired
	assign rd_data_a = (rd_addr_a == 5'd0) ? 32'b0 : regs[rd_addr_a];
	assign rd_data_b = (rd_addr_b == 5'd0) ? 32'b0 : regs[rd_addr_b];

endmodule

// File: hdl/control_unit.sv
`timescale 1ns/10ps

module control_unit (
	input  logic                 clk,
	input  logic                 rstb,
	input  mips_isa_pkg::instr_u instr,	// instruction register
	output mips_ctrl_pkg::ctrl_t ctrl
);
	import mips_isa_pkg::*;
	import mips_ctrl_pkg::*;

	state_e state;
	state_e state_next;

	// r-type funct to alu operation, unknown funct falls back to add
	function automatic alu_op_e funct_to_op(input funct_e funct);
		case (funct)
			fn_add:  return alu_add;
			fn_sub:  return alu_sub;
			fn_and:  return alu_and;
			fn_or:   return alu_or;
			fn_slt:  return alu_slt;
			fn_sll:  return alu_sll;
			default: return alu_add;
		endcase
	endfunction

	// immediate opcode to alu operation
	function automatic alu_op_e imm_to_op(input opcode_e opcode);
		case (opcode)
			op_andi: return alu_and;
			op_ori:  return alu_or;
			default: return alu_add;	// addi
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (!rstb) begin
			state <= st_fetch;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = st_fetch;	// terminal states all return here
		case (state)
			st_fetch: state_next = st_decode;
			st_decode: begin
				case (instr.r.opcode)
					op_r_type:               state_next = st_r_exec;
					op_addi, op_andi, op_ori: state_next = st_i_exec;
					op_lw, op_sw:            state_next = st_mem_addr;
					op_beq, op_bne:          state_next = st_branch;
					op_j, op_jal:            state_next = st_jump;
					default:                 state_next = st_fetch;	// unsupported opcode
				endcase
			end
			st_mem_addr: state_next = (instr.i.opcode == op_lw) ? st_mem_read : st_mem_write;
			st_mem_read: state_next = st_mem_wb;
			st_r_exec:   state_next = st_alu_wb;
			st_i_exec:   state_next = st_alu_wb;
			default:     state_next = st_fetch;
		endcase
	end

	// moore outputs, only the state and the held instruction matter
	always_comb begin
		ctrl = ctrl_default;
		case (state)
			st_fetch: begin
				ctrl.ir_write = 1'b1;	// ir takes mem_rd_data at the edge
				ctrl.pc_write = 1'b1;	// pc <= pc + 4
				ctrl.src_a    = src_a_pc;
				ctrl.src_b    = src_b_four;
				ctrl.pc_src   = pc_src_alu_result;
			end
			st_decode: begin
				// speculative branch target into alu_out
				ctrl.src_a = src_a_pc;
				ctrl.src_b = src_b_ext_shifted;
			end
			st_mem_addr: begin
				ctrl.src_a = src_a_reg_a;
				ctrl.src_b = src_b_ext;	// base + signed offset
			end
			st_mem_read: begin
				ctrl.i_or_d = 1'b1;	// mdr loads here
			end
			st_mem_wb: begin
				ctrl.reg_write  = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.reg_dst    = reg_dst_rt;
			end
			st_mem_write: begin
				ctrl.i_or_d    = 1'b1;
				ctrl.mem_write = 1'b1;	// single-cycle strobe
			end
			st_r_exec: begin
				ctrl.src_a  = (instr.r.funct == fn_sll) ? src_a_shamt : src_a_reg_a;
				ctrl.src_b  = src_b_reg_b;
				ctrl.alu_op = funct_to_op(instr.r.funct);
			end
			st_i_exec: begin
				ctrl.src_a    = src_a_reg_a;
				ctrl.src_b    = src_b_ext;
				ctrl.alu_op   = imm_to_op(instr.i.opcode);
				ctrl.zero_ext = (instr.i.opcode == op_andi) || (instr.i.opcode == op_ori);
			end
			st_alu_wb: begin
				ctrl.reg_write = 1'b1;
				ctrl.reg_dst   = (instr.r.opcode == op_r_type) ? reg_dst_rd : reg_dst_rt;
			end
			st_branch: begin
				ctrl.src_a  = src_a_reg_a;
				ctrl.src_b  = src_b_reg_b;
				ctrl.alu_op = alu_sub;	// zero flag means equal
				ctrl.pc_src = pc_src_alu_out;
				ctrl.branch = (instr.i.opcode == op_beq) ? branch_on_zero : branch_on_not_zero;
			end
			st_jump: begin
				ctrl.pc_write  = 1'b1;
				ctrl.pc_src    = pc_src_jump_target;
				ctrl.reg_write = (instr.j.opcode == op_jal);	// link only for jal
				ctrl.reg_dst   = reg_dst_link;
			end
			default: begin
				ctrl = ctrl_default;
			end
		endcase
	end

endmodule

// File: hdl/mips.sv
`timescale 1ns/10ps

module mips (
	input  logic        clk,
	input  logic        rstb,
	input  logic [31:0] mem_rd_data,	// instruction or load data
	output logic [31:0] mem_addr,
	output logic [31:0] mem_wr_data,
	output logic        mem_wr_ena,
	output logic [31:0] pc
);
	import mips_isa_pkg::*;
	import mips_ctrl_pkg::*;

	ctrl_t       ctrl;
	instr_u      ir;	// instruction register
	logic [31:0] mdr;	// memory-data register
	logic [31:0] reg_a;
	logic [31:0] reg_b;
	logic [31:0] alu_out;

	logic [31:0] rf_rd_a;
	logic [31:0] rf_rd_b;
	logic [31:0] src_a_val;
	logic [31:0] src_b_val;
	logic [31:0] alu_result;
	logic        alu_zero;
	logic [31:0] ext_imm;
	logic [31:0] jump_target;
	logic [4:0]  wb_addr;
	logic [31:0] wb_data;
	logic        pc_en;
	logic        mdr_load;

	control_unit u_ctrl (
		.clk   (clk),
		.rstb  (rstb),
		.instr (ir),
		.ctrl  (ctrl)
	);

	register_file u_rf (
		.clk       (clk),
		.rstb      (rstb),
		.rd_addr_a (ir.r.rs),
		.rd_addr_b (ir.r.rt),
		.wr_ena    (ctrl.reg_write),
		.wr_addr   (wb_addr),
		.wr_data   (wb_data),
		.rd_data_a (rf_rd_a),
		.rd_data_b (rf_rd_b)
	);

	alu u_alu (
		.a      (src_a_val),
		.b      (src_b_val),
		.op     (ctrl.alu_op),
		.result (alu_result),
		.zero   (alu_zero)
	);

	// 16 to 32 extension, zero for logical immediates
	assign ext_imm = ctrl.zero_ext ? {16'b0, ir.i.imm16} : {{16{ir.i.imm16[15]}}, ir.i.imm16};

	always_comb begin
		case (ctrl.src_a)
			src_a_reg_a: src_a_val = reg_a;
			src_a_shamt: src_a_val = {27'b0, ir.r.shamt};
			default:     src_a_val = pc;
		endcase
		case (ctrl.src_b)
			src_b_four:        src_b_val = 32'd4;
			src_b_ext:         src_b_val = ext_imm;
			src_b_ext_shifted: src_b_val = {ext_imm[29:0], 2'b00};	// word offset to bytes
			default:           src_b_val = reg_b;
		endcase
	end

	// write-back select
	always_comb begin
		case (ctrl.reg_dst)
			reg_dst_rd: begin
				wb_addr = ir.r.rd;
				wb_data = ctrl.mem_to_reg ? mdr : alu_out;
			end
			reg_dst_link: begin
				wb_addr = ra_reg;
				wb_data = pc;	// already pc + 4 of the jal
			end
			default: begin
				wb_addr = ir.i.rt;
				wb_data = ctrl.mem_to_reg ? mdr : alu_out;
			end
		endcase
	end

	assign jump_target = {pc[31:28], ir.j.target26, 2'b00};

	// unconditional write or branch condition met
	assign pc_en = ctrl.pc_write
		|| ((ctrl.branch == branch_on_zero) && alu_zero)
		|| ((ctrl.branch == branch_on_not_zero) && !alu_zero);

	assign mdr_load = ctrl.i_or_d && !ctrl.mem_write;	// mem_read state only

	always_ff @(posedge clk) begin
		if (!rstb) begin
			pc      <= '0;
			ir.raw  <= '0;
			mdr     <= '0;
			reg_a   <= '0;
			reg_b   <= '0;
			alu_out <= '0;
		end else begin
			reg_a   <= rf_rd_a;	// refreshed every cycle
			reg_b   <= rf_rd_b;
			alu_out <= alu_result;
			if (ctrl.ir_write) begin
				ir.raw <= mem_rd_data;
			end
			if (mdr_load) begin
				mdr <= mem_rd_data;
			end
			if (pc_en) begin
				case (ctrl.pc_src)
					pc_src_alu_out:     pc <= alu_out;
					pc_src_jump_target: pc <= jump_target;
					default:            pc <= alu_result;
				endcase
			end
		end
	end

	// memory port
	assign mem_addr    = ctrl.i_or_d ? alu_out : pc;
	assign mem_wr_data = reg_b;
	assign mem_wr_ena  = ctrl.mem_write;

endmodule

// File: dv/mips_properties.sv
`timescale 1ns/10ps

module mips_properties (
	input logic        clk,
	input logic        rstb,
	input logic [31:0] pc,
	input logic [31:0] mem_addr,
	input logic [31:0] mem_wr_data,
	input logic        mem_wr_ena
);

	localparam logic [31:0] trap_addr = 32'h0000_01fc;	// only poison stores aim here
	localparam logic [31:0] loop_next = 32'h0000_008c;	// pc once the end loop j is fetched

	int unsigned fail_count = 0;	// summed up by the testbench
	logic [11:0] seen;	// one bit per table entry
	logic [32:0] entry;
	logic [3:0]  slot;

	// expected store per data address, bit 32 flags a table entry
	function automatic logic [32:0] table_entry(input logic [31:0] addr);
		case (addr)
			32'h0000_0140: return {1'b1, 32'h0000_0004};	// add 7 + -3
			32'h0000_0144: return {1'b1, 32'h0000_000a};	// sub 7 - -3
			32'h0000_0148: return {1'b1, 32'h0000_0005};	// and
			32'h0000_014c: return {1'b1, 32'hffff_ffff};	// or
			32'h0000_0150: return {1'b1, 32'h0000_0001};	// slt -3 < 7
			32'h0000_0154: return {1'b1, 32'h0000_0070};	// sll 7 by 4
			32'h0000_0158: return {1'b1, 32'h0000_fff0};	// andi, zero extended
			32'h0000_015c: return {1'b1, 32'h0000_8001};	// ori, zero extended
			32'h0000_0160: return {1'b1, 32'h1234_567f};	// lw word + 7
			32'h0000_0164: return {1'b1, 32'h0000_0007};	// beq not taken marker
			32'h0000_0168: return {1'b1, 32'h0000_000a};	// bne not taken marker
			32'h0000_016c: return {1'b1, 32'h0000_0080};	// r31 after jal at 0x7c
			default:       return {1'b0, 32'h0000_0000};
		endcase
	endfunction

	assign entry = table_entry(mem_addr);
	assign slot  = mem_addr[5:2];	// table base is 64-byte aligned

	always_ff @(posedge clk) begin
		if (!rstb) begin
			seen <= '0;
		end else if (mem_wr_ena && entry[32]) begin
			seen[slot] <= 1'b1;
		end
	end

	// held in reset and on the first cycle after release
	reset_state: assert property (@(posedge clk)
		!rstb |=> (pc == 32'h0) && !mem_wr_ena && (mem_addr == 32'h0))
		else begin
			fail_count++;
			$error("CHECK FAILED at %0t: pc %h mem_addr %h after reset", $time, pc, mem_addr);
		end

	store_value: assert property (@(posedge clk) disable iff (!rstb)
		(mem_wr_ena && (mem_addr != trap_addr)) |-> entry[32] && (mem_wr_data == entry[31:0]))
		else begin
			fail_count++;
			$error("CHECK FAILED at %0t: store %h to %h", $time, mem_wr_data, mem_addr);
		end

	trap_untouched: assert property (@(posedge clk) disable iff (!rstb)
		mem_wr_ena |-> (mem_addr != trap_addr))
		else begin
			fail_count++;
			$error("a skipped path stored to the trap address at %0t", $time);
		end

	single_strobe: assert property (@(posedge clk) disable iff (!rstb)
		mem_wr_ena |=> !mem_wr_ena)
		else begin
			fail_count++;
			$error("write enable stayed high for two cycles at %0t", $time);
		end

	aligned_store: assert property (@(posedge clk) disable iff (!rstb)
		mem_wr_ena |-> (mem_addr[1:0] == 2'b00))
		else begin
			fail_count++;
			$error("CHECK FAILED at %0t: store address %h not word aligned", $time, mem_addr);
		end

	pc_aligned: assert property (@(posedge clk) disable iff (!rstb)
		pc[1:0] == 2'b00)
		else begin
			fail_count++;
			$error("CHECK FAILED at %0t: pc %h not word aligned", $time, pc);
		end

	// every kept store has landed once the end loop runs
	stores_complete: assert property (@(posedge clk) disable iff (!rstb)
		(pc == loop_next) |-> (seen == 12'hfff))
		else begin
			fail_count++;
			$error("CHECK FAILED at %0t: stores missing, seen mask %h", $time, seen);
		end

endmodule

bind mips mips_properties u_props (
	.clk         (clk),
	.rstb        (rstb),
	.pc          (pc),
	.mem_addr    (mem_addr),
	.mem_wr_data (mem_wr_data),
	.mem_wr_ena  (mem_wr_ena)
);

// File: dv/mips_tb.sv
`timescale 1ns/10ps

module mips_tb;

	localparam int max_instr = 60;	// program is 35 words, margin for the end loop
	localparam int cycle_limit = 2 * max_instr * 5;	// lw worst case, doubled
	localparam logic [31:0] end_pc = 32'h0000_0088;	// j to itself

	logic        clk = 1'b0;
	logic        rstb;
	logic [31:0] mem_rd_data;
	logic [31:0] mem_addr;
	logic [31:0] mem_wr_data;
	logic        mem_wr_ena;
	logic [31:0] pc;

	logic [31:0] mem [256];	// word addressed, data from word 64 up
	int          prog_idx;
	int          store_count;
	int          cycles;
	int          loop_cycles;
	int          timeout_errors;
	int          total_errors;

	mips dut (
		.clk         (clk),
		.rstb        (rstb),
		.mem_rd_data (mem_rd_data),
		.mem_addr    (mem_addr),
		.mem_wr_data (mem_wr_data),
		.mem_wr_ena  (mem_wr_ena),
		.pc          (pc)
	);

	function automatic logic [31:0] r_instr(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] shamt, input logic [5:0] funct);
		return {6'h00, rs, rt, rd, shamt, funct};
	endfunction

	function automatic logic [31:0] i_instr(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// target given as a byte address
	function automatic logic [31:0] j_instr(input logic [5:0] op, input logic [31:0] target);
		return {op, target[27:2]};
	endfunction

	task automatic emit(input logic [31:0] word);
		mem[prog_idx] = word;
		prog_idx++;
	endtask

	task automatic load_program();
		for (int i = 0; i < 256; i++) begin
			mem[i] = 32'hbad0_0000 | i;	// unique per word
		end
		mem[64] = 32'h1234_5678;	// lw source at 0x100
		prog_idx = 0;
		emit(i_instr(6'h08, 5'd0, 5'd1, 16'd7));	// 00 addi r1 = 7
		emit(i_instr(6'h08, 5'd0, 5'd2, 16'hfffd));	// 04 addi r2 = -3
		emit(r_instr(5'd1, 5'd2, 5'd3, 5'd0, 6'h20));	// 08 add r3
		emit(i_instr(6'h2b, 5'd0, 5'd3, 16'h0140));
		emit(r_instr(5'd1, 5'd2, 5'd4, 5'd0, 6'h22));	// 10 sub r4
		emit(i_instr(6'h2b, 5'd0, 5'd4, 16'h0144));
		emit(r_instr(5'd1, 5'd2, 5'd5, 5'd0, 6'h24));	// 18 and r5
		emit(i_instr(6'h2b, 5'd0, 5'd5, 16'h0148));
		emit(r_instr(5'd1, 5'd2, 5'd6, 5'd0, 6'h25));	// 20 or r6, also the poison word
		emit(i_instr(6'h2b, 5'd0, 5'd6, 16'h014c));
		emit(r_instr(5'd2, 5'd1, 5'd7, 5'd0, 6'h2a));	// 28 slt r7 = (r2 < r1)
		emit(i_instr(6'h2b, 5'd0, 5'd7, 16'h0150));
		emit(r_instr(5'd0, 5'd1, 5'd8, 5'd4, 6'h00));	// 30 sll r8 = r1 << 4
		emit(i_instr(6'h2b, 5'd0, 5'd8, 16'h0154));
		emit(i_instr(6'h0c, 5'd2, 5'd9, 16'hfff0));	// 38 andi r9
		emit(i_instr(6'h2b, 5'd0, 5'd9, 16'h0158));
		emit(i_instr(6'h0d, 5'd0, 5'd10, 16'h8001));	// 40 ori r10
		emit(i_instr(6'h2b, 5'd0, 5'd10, 16'h015c));
		emit(i_instr(6'h23, 5'd0, 5'd11, 16'h0100));	// 48 lw r11
		emit(r_instr(5'd11, 5'd1, 5'd12, 5'd0, 6'h20));	// 4c add r12 = r11 + r1
		emit(i_instr(6'h2b, 5'd0, 5'd12, 16'h0160));
		emit(i_instr(6'h04, 5'd1, 5'd1, 16'd1));	// 54 beq taken
		emit(i_instr(6'h2b, 5'd0, 5'd6, 16'h01fc));	// poison
		emit(i_instr(6'h04, 5'd1, 5'd2, 16'd1));	// 5c beq not taken
		emit(i_instr(6'h2b, 5'd0, 5'd1, 16'h0164));	// marker 7
		emit(i_instr(6'h05, 5'd1, 5'd2, 16'd1));	// 64 bne taken
		emit(i_instr(6'h2b, 5'd0, 5'd6, 16'h01fc));	// poison
		emit(i_instr(6'h05, 5'd1, 5'd1, 16'd1));	// 6c bne not taken
		emit(i_instr(6'h2b, 5'd0, 5'd4, 16'h0168));	// marker 10
		emit(j_instr(6'h02, 32'h0000_007c));	// 74 j over poison
		emit(i_instr(6'h2b, 5'd0, 5'd6, 16'h01fc));
		emit(j_instr(6'h03, 32'h0000_0084));	// 7c jal, r31 = 0x80
		emit(i_instr(6'h2b, 5'd0, 5'd6, 16'h01fc));
		emit(i_instr(6'h2b, 5'd0, 5'd31, 16'h016c));	// 84 store link
		emit(j_instr(6'h02, end_pc));	// 88 end loop
	endtask

	initial begin : clock_gen
		forever begin
			#4 clk = ~clk;
		end
	end

	// read data follows mem_addr mid cycle
	initial begin : memory_model
		mem_rd_data = '0;
		store_count = 0;
		load_program();
		forever begin
			@(negedge clk);
			mem_rd_data = mem[mem_addr[9:2]];
		end
	end

	// stores land at the rising edge that ends the mem_write state
	always @(posedge clk) begin : store_port
		if (mem_wr_ena) begin
			mem[mem_addr[9:2]] = mem_wr_data;
			store_count++;
		end
	end

	initial begin : run_program
		rstb = 1'b0;
		cycles = 0;
		loop_cycles = 0;
		timeout_errors = 0;
		repeat (4) @(negedge clk);
		rstb = 1'b1;
		while ((loop_cycles < 8) && (cycles < cycle_limit)) begin
			@(negedge clk);
			cycles++;
			if ((pc == end_pc) || (pc == end_pc + 32'd4)) begin	// j refetch bumps pc by 4
				loop_cycles++;
			end else begin
				loop_cycles = 0;
			end
		end
		repeat (2) @(negedge clk);	// last samples of the properties
		if (loop_cycles < 8) begin
			timeout_errors++;
			$display("timeout: program did not reach its end loop");
		end
		total_errors = timeout_errors + dut.u_props.fail_count;
		$display("errors: %0d assertion, %0d timeout (%0d stores in %0d cycles)",
			dut.u_props.fail_count, timeout_errors, store_count, cycles);
		if (total_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: sim.f
hdl/mips_isa_pkg.sv
hdl/mips_ctrl_pkg.sv
hdl/alu.sv
hdl/register_file.sv
hdl/control_unit.sv
hdl/mips.sv
dv/mips_properties.sv
dv/mips_tb.sv

// File: run_sim.sh
#!/bin/bash
# build and run the mips testbench with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

# a compile error or an aborted run also counts as a failure
verilator --binary --timing --assert -f sim.f --top-module mips_tb > sim.log 2>&1 &&
	./obj_dir/Vmips_tb +verilator+error+limit+1000 >> sim.log 2>&1 ||
	echo "Simulation failed" >> sim.log

grep -q "Simulation failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }
echo "PASS"
exit 0
